/* lms_defs.svh */
`ifndef LMS_DEFS_SVH
`define LMS_DEFS_SVH

// filter geometry
`define LMS_TAPS        32
`define LMS_TAP_W       5

// datapath widths
`define LMS_SAMPLE_W    14
`define LMS_WEIGHT_W    16
`define LMS_PROD_W      29
`define LMS_POWER_W     32

// power estimate is scaled down by 2^5 before the divide
`define LMS_NORM_SHIFT  5

// request buffer depth, equal to the credits handed to the sender
`define LMS_CREDITS     2

`endif

/* lms_pkg.sv */
`include "lms_defs.svh"

package lms_pkg;

    // error and reference samples
    typedef logic signed [`LMS_SAMPLE_W-1:0] sample_t;

    // stored tap weight
    typedef logic signed [`LMS_WEIGHT_W-1:0] weight_t;

    // err * ref product, also the signed quotient
    typedef logic signed [`LMS_PROD_W-1:0] prod_t;

    typedef logic [`LMS_TAP_W-1:0] tap_t;

    // update controller states
    typedef enum logic [1:0] {
        UPD_IDLE  = 2'd0,
        UPD_MUL   = 2'd1,
        UPD_DIV   = 2'd2,
        UPD_WRITE = 2'd3
    } upd_state_t;

endpackage

/* lms_req_fifo.sv */
`timescale 1ns/1ps
`include "lms_defs.svh"

module lms_req_fifo (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     push,
    input  lms_pkg::tap_t            push_tap,
    input  lms_pkg::sample_t         push_err,
    input  lms_pkg::sample_t         push_ref,
    input  logic [`LMS_POWER_W-1:0]  push_power,
    input  logic                     fifo_pop,
    output logic                     fifo_valid,
    output lms_pkg::tap_t            head_tap,
    output lms_pkg::sample_t         head_err,
    output lms_pkg::sample_t         head_ref,
    output logic [`LMS_POWER_W-1:0]  head_power,
    output logic                     credit_return
);

    localparam int DEPTH = `LMS_CREDITS;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    lms_pkg::tap_t            tap_q   [DEPTH];
    lms_pkg::sample_t         err_q   [DEPTH];
    lms_pkg::sample_t         ref_q   [DEPTH];
    logic [`LMS_POWER_W-1:0]  power_q [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign fifo_valid = (count != '0);
    assign do_pop     = fifo_pop && fifo_valid;
    // full buffer still takes a push when the head leaves in the same cycle
    assign do_push    = push && ((count != CNT_W'(DEPTH)) || do_pop);

    // one credit back per entry released
    assign credit_return = do_pop;

    assign head_tap   = tap_q[rd_ptr];
    assign head_err   = err_q[rd_ptr];
    assign head_ref   = ref_q[rd_ptr];
    assign head_power = power_q[rd_ptr];

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_push)
        begin
            tap_q[wr_ptr]   <= push_tap;
            err_q[wr_ptr]   <= push_err;
            ref_q[wr_ptr]   <= push_ref;
            power_q[wr_ptr] <= push_power;
        end
    end

endmodule

/* lms_step_divider.sv */
`timescale 1ns/1ps
`include "lms_defs.svh"

module lms_step_divider (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    div_start,
    input  logic [`LMS_PROD_W-1:0]  dividend_mag,
    input  logic [`LMS_PROD_W-1:0]  divisor_mag,
    input  logic                    neg,
    output logic                    div_done,
    output lms_pkg::prod_t          quotient
);

    localparam int W     = `LMS_PROD_W;
    localparam int CNT_W = $clog2(W);

    logic             busy;
    logic [CNT_W-1:0] bit_cnt;
    logic             last_bit;

    logic [W-1:0] rem;
    logic [W-1:0] q;
    logic [W-1:0] dvs;
    logic         neg_r;

    logic [W:0]   rem_shift;
    logic [W:0]   rem_diff;
    logic         fits;
    logic [W-1:0] rem_next;
    logic [W-1:0] q_next;

    // bring down the next dividend bit, subtract if the divisor fits
    assign rem_shift = {rem, q[W-1]};
    assign rem_diff  = rem_shift - {1'b0, dvs};
    assign fits      = (rem_shift >= {1'b0, dvs});
    assign rem_next  = fits ? rem_diff[W-1:0] : rem_shift[W-1:0];
    assign q_next    = {q[W-2:0], fits};

    assign last_bit = busy && (bit_cnt == CNT_W'(W - 1));

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            busy     <= 1'b0;
            bit_cnt  <= '0;
            div_done <= 1'b0;
        end
        else
        begin
            div_done <= 1'b0;
            if (div_start)
            begin
                busy    <= 1'b1;
                bit_cnt <= '0;
            end
            else if (last_bit)
            begin
                busy     <= 1'b0;
                div_done <= 1'b1;
            end
            else if (busy)
                bit_cnt <= bit_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (div_start)
        begin
            rem   <= '0;
            q     <= dividend_mag;
            dvs   <= divisor_mag;
            neg_r <= neg;
        end
        else if (busy)
        begin
            rem <= rem_next;
            q   <= q_next;
            // sign goes on last, so the result truncates toward zero
            if (last_bit)
            begin
                if (dvs == '0)
                    quotient <= '0;
                else
                    quotient <= neg_r ? -lms_pkg::prod_t'(q_next) : lms_pkg::prod_t'(q_next);
            end
        end
    end

endmodule

/* lms_weight_bank.sv */
`timescale 1ns/1ps
`include "lms_defs.svh"

module lms_weight_bank (
    input  logic              clk,
    input  logic              rstn,
    input  logic              wr_en,
    input  lms_pkg::tap_t     wr_tap,
    input  lms_pkg::weight_t  wr_data,
    input  lms_pkg::tap_t     cur_tap,
    input  lms_pkg::tap_t     rd_tap,
    output lms_pkg::weight_t  cur_weight,
    output lms_pkg::weight_t  rd_weight
);

    lms_pkg::weight_t weights [`LMS_TAPS];

    // old weight for the update in flight
    assign cur_weight = weights[cur_tap];

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            for (int i = 0; i < `LMS_TAPS; i++)
                weights[i] <= '0;
        end
        else if (wr_en)
            weights[wr_tap] <= wr_data;
    end

    // readback lags rd_tap by one cycle
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            rd_weight <= '0;
        else
            rd_weight <= weights[rd_tap];
    end

endmodule

/* lms_update_ctrl.sv */
`timescale 1ns/1ps
`include "lms_defs.svh"

module lms_update_ctrl (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     fifo_valid,
    input  lms_pkg::tap_t            head_tap,
    input  lms_pkg::sample_t         head_err,
    input  lms_pkg::sample_t         head_ref,
    input  logic [`LMS_POWER_W-1:0]  head_power,
    input  lms_pkg::weight_t         cur_weight,
    input  logic                     div_done,
    input  lms_pkg::prod_t           quotient,
    output logic                     fifo_pop,
    output lms_pkg::tap_t            cur_tap,
    output logic                     div_start,
    output logic [`LMS_PROD_W-1:0]   dividend_mag,
    output logic [`LMS_PROD_W-1:0]   divisor_mag,
    output logic                     neg,
    output logic                     wr_en,
    output lms_pkg::tap_t            wr_tap,
    output lms_pkg::weight_t         wr_data,
    output logic                     upd_done,
    output lms_pkg::tap_t            upd_tap
);

    lms_pkg::upd_state_t state;
    lms_pkg::upd_state_t state_nxt;

    lms_pkg::tap_t    tap_r;
    lms_pkg::prod_t   prod_r;
    lms_pkg::prod_t   dvs_r;
    lms_pkg::weight_t old_w_r;

    logic signed [`LMS_POWER_W-1:0] power_shr;

    // sign-extended power >> 5, only the low PROD_W bits are kept
    assign power_shr = $signed(head_power) >>> `LMS_NORM_SHIFT;

    assign fifo_pop = (state == lms_pkg::UPD_IDLE) && fifo_valid;

    always_comb
    begin
        state_nxt = state;
        case (state)
            lms_pkg::UPD_IDLE:
                if (fifo_valid)
                    state_nxt = lms_pkg::UPD_MUL;
            lms_pkg::UPD_MUL:
                state_nxt = lms_pkg::UPD_DIV;
            lms_pkg::UPD_DIV:
                if (div_done)
                    state_nxt = lms_pkg::UPD_WRITE;
            lms_pkg::UPD_WRITE:
                state_nxt = lms_pkg::UPD_IDLE;
            default:
                state_nxt = lms_pkg::UPD_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            state <= lms_pkg::UPD_IDLE;
        else
            state <= state_nxt;
    end

    // request fields leave the buffer on the pop edge
    always_ff @(posedge clk)
    begin
        if (fifo_pop)
        begin
            tap_r  <= head_tap;
            prod_r <= lms_pkg::prod_t'(head_err) * lms_pkg::prod_t'(head_ref);
            dvs_r  <= power_shr[`LMS_PROD_W-1:0];
        end
        if (state == lms_pkg::UPD_MUL)
            old_w_r <= cur_weight;
    end

    assign cur_tap = tap_r;

    // divider runs on magnitudes, sign travels separately
    assign div_start    = (state == lms_pkg::UPD_MUL);
    assign dividend_mag = prod_r[`LMS_PROD_W-1] ? -prod_r : prod_r;
    assign divisor_mag  = dvs_r[`LMS_PROD_W-1] ? -dvs_r : dvs_r;
    assign neg          = prod_r[`LMS_PROD_W-1] ^ dvs_r[`LMS_PROD_W-1];

    // wraps modulo 2^16
    assign wr_en    = (state == lms_pkg::UPD_WRITE);
    assign wr_tap   = tap_r;
    assign wr_data  = old_w_r + quotient[`LMS_WEIGHT_W-1:0];

    assign upd_done = (state == lms_pkg::UPD_WRITE);
    assign upd_tap  = tap_r;

endmodule

/* lms_weight_top.sv */
`timescale 1ns/1ps
`include "lms_defs.svh"

module lms_weight_top (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     req_valid,
    input  lms_pkg::tap_t            req_tap,
    input  lms_pkg::sample_t         req_err,
    input  lms_pkg::sample_t         req_ref,
    input  logic [`LMS_POWER_W-1:0]  req_power,
    input  lms_pkg::tap_t            rd_tap,
    output logic                     credit_return,
    output logic                     upd_done,
    output lms_pkg::tap_t            upd_tap,
    output lms_pkg::weight_t         rd_weight
);

    // buffer to controller
    logic                     fifo_valid;
    logic                     fifo_pop;
    lms_pkg::tap_t            head_tap;
    lms_pkg::sample_t         head_err;
    lms_pkg::sample_t         head_ref;
    logic [`LMS_POWER_W-1:0]  head_power;

    // controller to divider
    logic                     div_start;
    logic [`LMS_PROD_W-1:0]   dividend_mag;
    logic [`LMS_PROD_W-1:0]   divisor_mag;
    logic                     neg;
    logic                     div_done;
    lms_pkg::prod_t           quotient;

    // controller to bank
    lms_pkg::tap_t            cur_tap;
    lms_pkg::weight_t         cur_weight;
    logic                     wr_en;
    lms_pkg::tap_t            wr_tap;
    lms_pkg::weight_t         wr_data;

    lms_req_fifo fifo_i (
        .clk           (clk),
        .rstn          (rstn),
        .push          (req_valid),
        .push_tap      (req_tap),
        .push_err      (req_err),
        .push_ref      (req_ref),
        .push_power    (req_power),
        .fifo_pop      (fifo_pop),
        .fifo_valid    (fifo_valid),
        .head_tap      (head_tap),
        .head_err      (head_err),
        .head_ref      (head_ref),
        .head_power    (head_power),
        .credit_return (credit_return)
    );

    lms_update_ctrl ctrl_i (
        .clk          (clk),
        .rstn         (rstn),
        .fifo_valid   (fifo_valid),
        .head_tap     (head_tap),
        .head_err     (head_err),
        .head_ref     (head_ref),
        .head_power   (head_power),
        .cur_weight   (cur_weight),
        .div_done     (div_done),
        .quotient     (quotient),
        .fifo_pop     (fifo_pop),
        .cur_tap      (cur_tap),
        .div_start    (div_start),
        .dividend_mag (dividend_mag),
        .divisor_mag  (divisor_mag),
        .neg          (neg),
        .wr_en        (wr_en),
        .wr_tap       (wr_tap),
        .wr_data      (wr_data),
        .upd_done     (upd_done),
        .upd_tap      (upd_tap)
    );

    lms_step_divider div_i (
        .clk          (clk),
        .rstn         (rstn),
        .div_start    (div_start),
        .dividend_mag (dividend_mag),
        .divisor_mag  (divisor_mag),
        .neg          (neg),
        .div_done     (div_done),
        .quotient     (quotient)
    );

    lms_weight_bank bank_i (
        .clk        (clk),
        .rstn       (rstn),
        .wr_en      (wr_en),
        .wr_tap     (wr_tap),
        .wr_data    (wr_data),
        .cur_tap    (cur_tap),
        .rd_tap     (rd_tap),
        .cur_weight (cur_weight),
        .rd_weight  (rd_weight)
    );

endmodule

/* lms_weight_tb.sv */
`timescale 1ns/1ps
`include "lms_defs.svh"

module lms_weight_tb;

    localparam int N_DIRECTED = 3;
    localparam int N_ACCUM    = 6;
    localparam int N_BURST    = 40;
    localparam int N_REQ      = N_DIRECTED + N_ACCUM + N_BURST;
    // margin covers reset and the readback sweeps
    localparam int WATCHDOG_CYCLES = N_REQ * 40 + 400;

    logic                     clk;
    logic                     rstn;
    logic                     req_valid;
    lms_pkg::tap_t            req_tap;
    lms_pkg::sample_t         req_err;
    lms_pkg::sample_t         req_ref;
    logic [`LMS_POWER_W-1:0]  req_power;
    lms_pkg::tap_t            rd_tap;
    logic                     credit_return;
    logic                     upd_done;
    lms_pkg::tap_t            upd_tap;
    lms_pkg::weight_t         rd_weight;

    lms_pkg::weight_t shadow [`LMS_TAPS];
    lms_pkg::tap_t    exp_tap_q [$];
    lms_pkg::tap_t    exp_tap;
    int               errors = 0;
    int               returned = 0;
    int               done_count = 0;
    int               sent;
    int               credits;
    integer           seed;

    lms_weight_top dut_i (
        .clk           (clk),
        .rstn          (rstn),
        .req_valid     (req_valid),
        .req_tap       (req_tap),
        .req_err       (req_err),
        .req_ref       (req_ref),
        .req_power     (req_power),
        .rd_tap        (rd_tap),
        .credit_return (credit_return),
        .upd_done      (upd_done),
        .upd_tap       (upd_tap),
        .rd_weight     (rd_weight)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // NLMS step applied to the shadow copy
    function automatic lms_pkg::weight_t lms_update_ref(
        input lms_pkg::tap_t    tap,
        input lms_pkg::sample_t err,
        input lms_pkg::sample_t rf,
        input logic [31:0]      power
    );
        longint                         prod;
        logic signed [31:0]             scaled;
        logic signed [`LMS_PROD_W-1:0]  norm;
        longint                         divisor;
        longint                         step;
        prod    = longint'(err) * longint'(rf);
        scaled  = $signed(power) >>> `LMS_NORM_SHIFT;
        // only 29 bits of the scaled power reach the divider
        norm    = scaled[`LMS_PROD_W-1:0];
        divisor = longint'(norm);
        if (divisor == 0)
            step = '0;
        else
            step = prod / divisor;
        shadow[tap] = shadow[tap] + step[15:0];
        return shadow[tap];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            errors = errors + 1;
        end
    endtask

    // waits for a credit and pulses req_valid for one cycle
    task automatic send_req(
        input lms_pkg::tap_t    tap,
        input lms_pkg::sample_t err,
        input lms_pkg::sample_t rf,
        input logic [31:0]      power
    );
        credits = `LMS_CREDITS - sent + returned;
        while (credits <= 0)
        begin
            @(negedge clk);
            credits = `LMS_CREDITS - sent + returned;
        end
        req_valid = 1'b1;
        req_tap   = tap;
        req_err   = err;
        req_ref   = rf;
        req_power = power;
        sent      = sent + 1;
        credits   = credits - 1;
        exp_tap_q.push_back(tap);
        void'(lms_update_ref(tap, err, rf, power));
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic wait_idle();
        int n;
        int limit;
        n     = 0;
        limit = 40 * (exp_tap_q.size() + 1);
        while (exp_tap_q.size() != 0 && n < limit)
        begin
            @(negedge clk);
            n = n + 1;
        end
        if (exp_tap_q.size() != 0)
        begin
            $display("no upd_done for %0d outstanding updates", exp_tap_q.size());
            errors = errors + 1;
            exp_tap_q.delete();
        end
        @(negedge clk);
    endtask

    // registered readback lags rd_tap by one cycle
    task automatic read_weight(input lms_pkg::tap_t tap, output lms_pkg::weight_t w);
        rd_tap = tap;
        @(negedge clk);
        w = rd_weight;
    endtask

    task automatic sweep_check();
        lms_pkg::weight_t w;
        for (int t = 0; t < `LMS_TAPS; t++)
        begin
            read_weight(lms_pkg::tap_t'(t), w);
            check_value($sformatf("rd_weight[%0d]", t), 32'(w), 32'(shadow[t]));
        end
    endtask

    // completions must come back in request order
    always @(posedge clk)
    begin
        if (rstn && upd_done)
        begin
            if (exp_tap_q.size() == 0)
            begin
                $display("upd_done fired with no update outstanding");
                errors = errors + 1;
            end
            else
            begin
                exp_tap = exp_tap_q.pop_front();
                check_value("upd_tap", 32'(upd_tap), 32'(exp_tap));
            end
            done_count = done_count + 1;
        end
    end

    // one update in arithmetic, so at most one credit ahead of upd_done
    always @(posedge clk)
    begin
        if (rstn && credit_return)
        begin
            returned = returned + 1;
            if (returned > sent)
            begin
                $display("engine returned a credit for a request never sent");
                errors = errors + 1;
            end
            if (returned > done_count + 1)
            begin
                $display("engine returned a credit before the previous update finished");
                errors = errors + 1;
            end
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0t, %0d errors so far", $time, errors);
        $display("Result: FAILED");
        $finish;
    end

    initial
    begin
        lms_pkg::weight_t w;
        lms_pkg::tap_t    tap;
        lms_pkg::sample_t err;
        lms_pkg::sample_t rf;
        logic [31:0]      power;
        logic [31:0]      rnd;
        logic [31:0]      rnd2;
        seed        = 95;
        rstn        = 1'b0;
        req_valid   = 1'b0;
        req_tap     = '0;
        req_err     = '0;
        req_ref     = '0;
        req_power   = '0;
        rd_tap      = '0;
        sent        = 0;
        credits     = `LMS_CREDITS;
        for (int t = 0; t < `LMS_TAPS; t++)
            shadow[t] = '0;
        repeat (5) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);

        // bank is all zero out of reset
        sweep_check();

        send_req(5'd3, 14'sd1200, -14'sd350, 32'd3200);
        wait_idle();
        read_weight(5'd3, w);
        check_value("rd_weight[3]", 32'(w), 32'(shadow[3]));
        send_req(5'd7, -14'sd2000, -14'sd3000, 32'd32000);
        wait_idle();
        read_weight(5'd7, w);
        check_value("rd_weight[7]", 32'(w), 32'(shadow[7]));

        // power below 32 gives a zero divisor and leaves the weight as is
        send_req(5'd3, 14'sd4000, 14'sd4000, 32'd17);
        wait_idle();
        read_weight(5'd3, w);
        check_value("rd_weight[3]", 32'(w), 32'(shadow[3]));

        for (int i = 0; i < N_BURST; i++)
        begin
            rnd  = $random(seed);
            rnd2 = $random(seed);
            tap  = rnd[4:0];
            err  = rnd[18:5];
            rf   = rnd2[31:18];
            case (rnd[31:30])
                2'd0:    power = $random(seed);
                2'd1:    power = {27'd0, rnd2[4:0]};
                default: power = {14'd0, rnd2[17:0]};
            endcase
            send_req(tap, err, rf, power);
        end
        wait_idle();
        credits = `LMS_CREDITS - sent + returned;
        check_value("credits", credits, `LMS_CREDITS);

        // large steps on one tap wrap past 16 bits by the second update
        for (int i = 0; i < N_ACCUM; i++)
        begin
            err = (i == N_ACCUM - 1) ? 14'h2000 : 14'h1fff;
            send_req(5'd12, err, 14'h1fff, 32'h0001_0000);
        end
        wait_idle();
        read_weight(5'd12, w);
        check_value("rd_weight[12]", 32'(w), 32'(shadow[12]));

        sweep_check();
        check_value("upd_done count", done_count, sent);

        $display("errors: %0d, updates completed: %0d of %0d", errors, done_count, sent);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

/* flist.f */
+incdir+.
lms_pkg.sv
lms_req_fifo.sv
lms_step_divider.sv
lms_weight_bank.sv
lms_update_ctrl.sv
lms_weight_top.sv
lms_weight_tb.sv

/* Makefile */
TOP := lms_weight_tb

.PHONY: build run clean

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -f flist.f -o $(TOP)_sim

run: build
	./obj_dir/$(TOP)_sim > sim.log 2>&1; cat sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
